/* verilog/ibuf_defs.svh */
`ifndef IBUF_DEFS_SVH
`define IBUF_DEFS_SVH

////////////////////////////////////////
// internal buffer sizing
////////////////////////////////////////

// address width in 64-bit words
// buffer depth is 2**IBUF_AW
`define IBUF_AW 10

// writer stalls the backend stream
// once fewer free slots than this remain
// covers the beats still in flight while tready drops
`define IBUF_MARGIN 10

`endif

/* verilog/ibuf_pkg.sv */
`default_nettype none
`include "ibuf_defs.svh"

package ibuf_pkg;

    // buffer pointer, one bit wider than the ram address
    // top bit is the wrap flag, so full and empty differ
    // ram index is the low IBUF_AW bits only
    // descriptor word: [63:48] zero, [47:32] byte length, [31:0] zero
    typedef logic [`IBUF_AW:0] ibuf_ptr_t;

    // backend writer
    typedef enum logic [2:0] {
        WR_INIT,        // load first write slot
        WR_WAIT_HOST,   // hold off until host side is up
        WR_FIRST,       // waiting for first beat of a packet
        WR_DATA,        // rest of the packet
        WR_COMMIT,      // descriptor write + producer update
        WR_STALL        // almost full
    } wr_state_t;

    // host reader
    typedef enum logic [1:0] {
        RD_IDLE,
        RD_DESC,
        RD_DATA
    } rd_state_t;

endpackage

`default_nettype wire

/* verilog/ibuf_ram.sv */
`timescale 1ns/1ps
`default_nettype none
`include "ibuf_defs.svh"

module ibuf_ram (
    input  wire                 clk,
    // write side, from the backend writer
    input  wire                 wr_en,
    input  wire [`IBUF_AW-1:0]  wr_addr,
    input  wire [63:0]          wr_data,
    // read side, to the host reader
    input  wire [`IBUF_AW-1:0]  rd_addr,
    output logic [63:0]         rd_data
);

    localparam int DEPTH = 2 ** `IBUF_AW;

    logic [63:0] mem [0:DEPTH-1];

    ////////////////////////////////////////
    // write port
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read, data one cycle after the address
    // same-address collision returns the old word
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

/* verilog/bkd2ibuf.sv */
`timescale 1ns/1ps
`default_nettype none
`include "ibuf_defs.svh"

module bkd2ibuf (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         hst_rdy,        // host side up

    // backend stream
    input  wire [63:0]                  s_axis_tdata,
    input  wire [15:0]                  s_axis_tuser,   // byte length of the frame
    input  wire                         s_axis_tvalid,
    input  wire                         s_axis_tlast,
    output logic                        s_axis_tready,

    // buffer write port
    output logic                        wr_en,
    output logic [`IBUF_AW-1:0]         wr_addr,
    output logic [63:0]                 wr_data,

    // credits
    input  wire ibuf_pkg::ibuf_ptr_t    committed_cons, // from the reader
    output ibuf_pkg::ibuf_ptr_t         committed_prod  // descriptor slot of next packet
);

    import ibuf_pkg::*;

    localparam int DEPTH = 2 ** `IBUF_AW;

    wr_state_t      state;
    ibuf_ptr_t      wr_ptr;         // next data slot
    ibuf_ptr_t      used_slots;
    ibuf_ptr_t      free_slots;
    logic           low_space;
    logic           beat;           // accepted beat
    logic           in_pkt;         // stall entered mid packet
    logic           hst_rdy_q;
    logic [15:0]    pkt_len;        // latched on first beat

    ////////////////////////////////////////
    // credit check
    ////////////////////////////////////////
    assign beat       = s_axis_tvalid & s_axis_tready;
    assign used_slots = wr_ptr - committed_cons;            // includes reserved descriptor slot
    assign free_slots = ibuf_ptr_t'(DEPTH) - used_slots;
    assign low_space  = (free_slots < ibuf_ptr_t'(`IBUF_MARGIN));

    ////////////////////////////////////////
    // writer fsm
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state          <= WR_INIT;
            s_axis_tready  <= 1'b0;
            wr_en          <= 1'b0;
            committed_prod <= '0;
            wr_ptr         <= '0;
            in_pkt         <= 1'b0;
            hst_rdy_q      <= 1'b0;
        end else begin
            hst_rdy_q <= hst_rdy;
            wr_en     <= 1'b0;                              // one-shot

            case (state)
                WR_INIT: begin
                    wr_ptr <= committed_prod + 1'b1;        // skip first descriptor slot
                    state  <= WR_WAIT_HOST;
                end

                WR_WAIT_HOST: begin
                    if (hst_rdy_q) begin
                        s_axis_tready <= 1'b1;
                        state         <= WR_FIRST;
                    end
                end

                WR_FIRST, WR_DATA: begin
                    if (beat) begin
                        wr_en   <= 1'b1;
                        wr_addr <= wr_ptr[`IBUF_AW-1:0];
                        wr_data <= s_axis_tdata;
                        wr_ptr  <= wr_ptr + 1'b1;
                        if (state == WR_FIRST) begin
                            pkt_len <= s_axis_tuser;
                        end
                    end

                    // end of packet wins over the space check
                    if (beat && s_axis_tlast) begin
                        s_axis_tready <= 1'b0;              // low for the commit cycle only
                        state         <= WR_COMMIT;
                    end else if (low_space) begin
                        s_axis_tready <= 1'b0;
                        in_pkt        <= beat || (state == WR_DATA);
                        state         <= WR_STALL;
                    end else if (beat) begin
                        state <= WR_DATA;
                    end
                end

                WR_COMMIT: begin
                    // descriptor goes into the slot reserved at packet start
                    wr_en          <= 1'b1;
                    wr_addr        <= committed_prod[`IBUF_AW-1:0];
                    wr_data        <= {16'h0000, pkt_len, 32'h0000_0000};
                    committed_prod <= wr_ptr;               // slot after last data word
                    wr_ptr         <= wr_ptr + 1'b1;        // reserve it, data goes behind
                    s_axis_tready  <= 1'b1;
                    state          <= WR_FIRST;
                end

                WR_STALL: begin
                    // wait for the reader to hand back slots
                    if (!low_space) begin
                        s_axis_tready <= 1'b1;
                        state         <= in_pkt ? WR_DATA : WR_FIRST;
                    end
                end

                default: begin
                    s_axis_tready <= 1'b0;
                    state         <= WR_INIT;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/ibuf2hst.sv */
`timescale 1ns/1ps
`default_nettype none
`include "ibuf_defs.svh"

module ibuf2hst (
    input  wire                         clk,
    input  wire                         rst,
    input  wire ibuf_pkg::ibuf_ptr_t    committed_prod,
    output logic [`IBUF_AW-1:0]         rd_addr,
    input  wire [63:0]                  rd_data,        // one cycle after rd_addr
    output ibuf_pkg::ibuf_ptr_t         committed_cons,
    output logic [63:0]                 m_axis_tdata,
    output logic [7:0]                  m_axis_tkeep,
    output logic                        m_axis_tvalid,
    output logic                        m_axis_tlast,
    input  wire                         m_axis_tready
);

    import ibuf_pkg::*;

    rd_state_t      state;
    ibuf_ptr_t      prod_q;         // descriptor reaches the ram one edge after commit
    ibuf_ptr_t      rd_ptr;         // address on the ram read port
    logic [13:0]    words_left;     // reads still to issue
    logic [7:0]     last_keep;
    logic [16:0]    len_rnd;
    logic           rd_pend;        // rd_data holds a packet word this cycle
    logic           rd_pend_last;
    logic           skid_valid;
    logic           skid_last;
    logic [63:0]    skid_data;
    logic           pop;
    logic           load_out;
    logic           issue;
    logic [1:0]     occ_next;       // words held next cycle, before a new read lands

    assign rd_addr  = rd_ptr[`IBUF_AW-1:0];
    assign pop      = m_axis_tvalid & m_axis_tready;
    assign load_out = pop | ~m_axis_tvalid;
    assign len_rnd  = {1'b0, rd_data[47:32]} + 17'd7;   // round up to whole words
    assign occ_next = 2'(m_axis_tvalid) + 2'(skid_valid) + 2'(rd_pend) - 2'(pop);
    // read ahead only while output reg + skid can take the word
    assign issue    = (state == RD_DATA) && (words_left != '0) && (occ_next <= 2'd1);

    ////////////////////////////////////////
    // reader fsm and valid bits
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state          <= RD_IDLE;
            prod_q         <= '0;
            rd_ptr         <= '0;
            committed_cons <= '0;
            words_left     <= '0;
            rd_pend        <= 1'b0;
            skid_valid     <= 1'b0;
            m_axis_tvalid  <= 1'b0;
        end else begin
            prod_q  <= committed_prod;
            rd_pend <= issue;

            case (state)
                RD_IDLE: begin
                    if (committed_cons != prod_q) begin   // descriptor read in flight
                        rd_ptr <= rd_ptr + 1'b1;
                        state  <= RD_DESC;
                    end
                end
                RD_DESC: begin
                    words_left <= len_rnd[16:3];
                    state      <= RD_DATA;
                end
                RD_DATA: begin
                    if (issue) begin
                        rd_ptr     <= rd_ptr + 1'b1;
                        words_left <= words_left - 1'b1;
                    end
                    if (pop && m_axis_tlast) begin
                        committed_cons <= rd_ptr;           // next descriptor slot
                        state          <= RD_IDLE;
                    end
                end
                default: state <= RD_IDLE;
            endcase

            if (load_out) begin
                m_axis_tvalid <= skid_valid | rd_pend;
                if (skid_valid) begin
                    skid_valid <= rd_pend;                  // refill behind the drained skid
                end
            end else if (rd_pend) begin
                skid_valid <= 1'b1;                         // output held, park the word
            end
        end
    end

    ////////////////////////////////////////
    // payload path
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (issue) begin
            rd_pend_last <= (words_left == 14'd1);
        end
        if (state == RD_DESC) begin
            // low (len mod 8) bytes, full word when it divides evenly
            last_keep <= (rd_data[34:32] == 3'd0) ? 8'hff
                                                  : (8'h01 << rd_data[34:32]) - 8'h01;
        end
        if (load_out) begin
            if (skid_valid) begin
                m_axis_tdata <= skid_data;
                m_axis_tlast <= skid_last;
                m_axis_tkeep <= skid_last ? last_keep : 8'hff;
            end else if (rd_pend) begin
                m_axis_tdata <= rd_data;
                m_axis_tlast <= rd_pend_last;
                m_axis_tkeep <= rd_pend_last ? last_keep : 8'hff;
            end
        end
        if (rd_pend && (!load_out || skid_valid)) begin
            skid_data <= rd_data;
            skid_last <= rd_pend_last;
        end
    end

endmodule

`default_nettype wire

/* verilog/rx_path_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "ibuf_defs.svh"

module rx_path_top (
    input  wire         clk,
    input  wire         rst,
    input  wire         hst_rdy,
    // backend stream in
    input  wire [63:0]  s_axis_tdata,
    input  wire [15:0]  s_axis_tuser,
    input  wire         s_axis_tvalid,
    input  wire         s_axis_tlast,
    output wire         s_axis_tready,
    // host stream out
    output wire [63:0]  m_axis_tdata,
    output wire [7:0]   m_axis_tkeep,
    output wire         m_axis_tvalid,
    output wire         m_axis_tlast,
    input  wire         m_axis_tready
);

    import ibuf_pkg::*;

    ////////////////////////////////////////
    // internal buffer links
    ////////////////////////////////////////
    logic                   wr_en;
    logic [`IBUF_AW-1:0]    wr_addr;
    logic [63:0]            wr_data;
    logic [`IBUF_AW-1:0]    rd_addr;
    logic [63:0]            rd_data;
    ibuf_ptr_t              committed_prod;     // writer to reader
    ibuf_ptr_t              committed_cons;     // reader back to writer

    bkd2ibuf bkd2ibuf_inst (
        .clk            (clk),
        .rst            (rst),
        .hst_rdy        (hst_rdy),
        .s_axis_tdata   (s_axis_tdata),
        .s_axis_tuser   (s_axis_tuser),
        .s_axis_tvalid  (s_axis_tvalid),
        .s_axis_tlast   (s_axis_tlast),
        .s_axis_tready  (s_axis_tready),
        .wr_en          (wr_en),
        .wr_addr        (wr_addr),
        .wr_data        (wr_data),
        .committed_cons (committed_cons),
        .committed_prod (committed_prod)
    );

    ibuf_ram ibuf_ram_inst (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    ibuf2hst ibuf2hst_inst (
        .clk            (clk),
        .rst            (rst),
        .committed_prod (committed_prod),
        .rd_addr        (rd_addr),
        .rd_data        (rd_data),
        .committed_cons (committed_cons),
        .m_axis_tdata   (m_axis_tdata),
        .m_axis_tkeep   (m_axis_tkeep),
        .m_axis_tvalid  (m_axis_tvalid),
        .m_axis_tlast   (m_axis_tlast),
        .m_axis_tready  (m_axis_tready)
    );

endmodule

`default_nettype wire

/* verif/rx_path_props.sv */
`timescale 1ns/1ps
`default_nettype none

module rx_path_props (
    input wire          clk,
    input wire          rst,
    input wire          s_axis_tvalid,
    input wire          s_axis_tready,
    input wire [63:0]   m_axis_tdata,
    input wire [7:0]    m_axis_tkeep,
    input wire          m_axis_tvalid,
    input wire          m_axis_tlast,
    input wire          m_axis_tready
);

    logic seen_in;      // first backend beat taken

    always_ff @(posedge clk) begin
        if (rst) begin
            seen_in <= 1'b0;
        end else if (s_axis_tvalid && s_axis_tready) begin
            seen_in <= 1'b1;
        end
    end

    ////////////////////////////////////////
    // port rules
    ////////////////////////////////////////

    // writer closed in reset and the two cycles after
    tready_after_reset: assert property (@(posedge clk)
        rst |=> (!s_axis_tready) [*2])
        else $error("s_axis_tready high during or right after reset");

    // output held while the host pushes back
    hold_on_backpressure: assert property (@(posedge clk) disable iff (rst)
        (m_axis_tvalid && !m_axis_tready) |=>
            (m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tkeep)
             && $stable(m_axis_tlast)))
        else $error("m_axis beat changed while stalled");

    no_output_before_input: assert property (@(posedge clk) disable iff (rst)
        !seen_in |-> !m_axis_tvalid)
        else $error("m_axis_tvalid high before any backend beat");

endmodule

bind rx_path_top rx_path_props rx_path_props_inst (.*);

`default_nettype wire

/* verif/rx_path_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module rx_path_tb;

    localparam int NUM_PKTS = 240;                      // ~3 buffer depths of slots
    localparam int CLK_HALF = 20;                       // 40 ns period
    localparam int TIMEOUT  = NUM_PKTS * 26 * 8 * 40;   // ns

    logic        clk;
    logic        rst;
    logic        hst_rdy;
    logic [63:0] s_axis_tdata;
    logic [15:0] s_axis_tuser;
    logic        s_axis_tvalid;
    logic        s_axis_tlast;
    logic        s_axis_tready;
    logic [63:0] m_axis_tdata;
    logic [7:0]  m_axis_tkeep;
    logic        m_axis_tvalid;
    logic        m_axis_tlast;
    logic        m_axis_tready;

    logic [63:0] in_words[$];       // words of the packet coming in
    logic [72:0] exp_q[$];          // {tlast, tkeep, tdata}
    int          pkts_out;
    int          err_data;
    int          err_keep;
    int          err_last;
    int          err_other;
    int          low_run;
    bit          stall_seen;        // almost-full backpressure observed

    rx_path_top rx_path_top_inst (
        .clk           (clk),
        .rst           (rst),
        .hst_rdy       (hst_rdy),
        .s_axis_tdata  (s_axis_tdata),
        .s_axis_tuser  (s_axis_tuser),
        .s_axis_tvalid (s_axis_tvalid),
        .s_axis_tlast  (s_axis_tlast),
        .s_axis_tready (s_axis_tready),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tkeep  (m_axis_tkeep),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tlast  (m_axis_tlast),
        .m_axis_tready (m_axis_tready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_HALF) clk = ~clk;
    end

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////

    // beat idx of a len-byte packet, keep marks the bytes that exist
    function automatic logic [72:0] expected_beat(input int len, input int idx,
                                                  input logic [63:0] word);
        int         nwords;
        logic [7:0] keep;
        nwords = (len + 7) / 8;
        for (int b = 0; b < 8; b++) begin
            keep[b] = (idx * 8 + b < len);
        end
        return {idx == nwords - 1, keep, word};
    endfunction

    task automatic send_packets();
        int len;
        int nwords;
        for (int p = 0; p < NUM_PKTS; p++) begin
            len    = $urandom_range(200, 1);
            nwords = (len + 7) / 8;
            for (int w = 0; w < nwords; w++) begin
                if ($urandom_range(3, 0) == 0) begin        // idle gap
                    s_axis_tvalid <= 1'b0;
                    repeat ($urandom_range(3, 1)) @(posedge clk);
                end
                s_axis_tvalid <= 1'b1;
                s_axis_tdata  <= {$urandom, $urandom};
                s_axis_tuser  <= 16'(len);
                s_axis_tlast  <= (w == nwords - 1);
                do @(posedge clk); while (!s_axis_tready);  // held until taken
            end
        end
        s_axis_tvalid <= 1'b0;
        s_axis_tlast  <= 1'b0;
    endtask

    task automatic drive_host_ready();
        m_axis_tready <= 1'b0;
        repeat (2500) @(posedge clk);       // long host stall, buffer fills up
        forever begin
            if ($urandom_range(1999, 0) == 0) begin
                m_axis_tready <= 1'b0;
                repeat ($urandom_range(600, 200)) @(posedge clk);
            end else begin
                m_axis_tready <= ($urandom_range(3, 0) != 0);
                @(posedge clk);
            end
        end
    endtask

    task automatic watch_input();
        forever begin
            @(posedge clk);
            if (s_axis_tvalid && !s_axis_tready) begin
                low_run++;
                if (low_run >= 3) begin         // longer than a commit cycle
                    stall_seen = 1'b1;
                end
            end else begin
                low_run = 0;
            end
            if (s_axis_tvalid && s_axis_tready) begin
                in_words.push_back(s_axis_tdata);
                if (s_axis_tlast) begin
                    foreach (in_words[i]) begin
                        exp_q.push_back(expected_beat(s_axis_tuser, i, in_words[i]));
                    end
                    in_words.delete();
                end
            end
        end
    endtask

    task automatic check_output();
        logic [72:0] want;
        forever begin
            @(posedge clk);
            if (m_axis_tvalid && m_axis_tready) begin
                assert (exp_q.size() != 0) else begin
                    err_other++;
                    $display("output beat at %0t with no input beat pending", $time);
                end
                if (exp_q.size() != 0) begin
                    want = exp_q.pop_front();
                    assert (m_axis_tdata === want[63:0]) else begin
                        err_data++;
                        $display("FAILED %0t m_axis_tdata expected %h got %h",
                                 $time, want[63:0], m_axis_tdata);
                    end
                    assert (m_axis_tkeep === want[71:64]) else begin
                        err_keep++;
                        $display("FAILED %0t m_axis_tkeep expected %h got %h",
                                 $time, want[71:64], m_axis_tkeep);
                    end
                    assert (m_axis_tlast === want[72]) else begin
                        err_last++;
                        $display("FAILED %0t m_axis_tlast expected %b got %b",
                                 $time, want[72], m_axis_tlast);
                    end
                end
                if (m_axis_tlast) begin
                    pkts_out++;
                end
            end
        end
    endtask

    task automatic report_counts();
        $display("errors: data %0d keep %0d last %0d other %0d",
                 err_data, err_keep, err_last, err_other);
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////
    initial begin
        void'($urandom(32'ha18e0a89));
        rst           = 1'b1;
        hst_rdy       = 1'b0;
        s_axis_tdata  = '0;
        s_axis_tuser  = '0;
        s_axis_tvalid = 1'b0;
        s_axis_tlast  = 1'b0;
        m_axis_tready = 1'b0;
        pkts_out      = 0;
        err_data      = 0;
        err_keep      = 0;
        err_last      = 0;
        err_other     = 0;
        low_run       = 0;
        stall_seen    = 1'b0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        // host not up yet, both streams must stay quiet
        repeat (20) begin
            @(posedge clk);
            assert (s_axis_tready === 1'b0) else begin
                err_other++;
                $display("FAILED %0t s_axis_tready expected 0 got %b", $time, s_axis_tready);
            end
            assert (m_axis_tvalid === 1'b0) else begin
                err_other++;
                $display("FAILED %0t m_axis_tvalid expected 0 got %b", $time, m_axis_tvalid);
            end
        end
        hst_rdy <= 1'b1;
        for (int n = 0; n < 10 && !s_axis_tready; n++) begin
            @(posedge clk);
        end
        assert (s_axis_tready) else begin
            err_other++;
            $display("s_axis_tready did not rise after hst_rdy was raised");
        end

        fork
            send_packets();
            drive_host_ready();
            watch_input();
            check_output();
        join_none

        wait (pkts_out == NUM_PKTS);
        repeat (10) @(posedge clk);
        assert (exp_q.size() == 0) else begin
            err_other++;
            $display("%0d expected beats never came out", exp_q.size());
        end
        assert (stall_seen) else begin
            err_other++;
            $display("backend stream never stalled on a nearly full buffer");
        end
        report_counts();
        if (err_data + err_keep + err_last + err_other == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(TIMEOUT);
        $display("timeout, only %0d of %0d packets came out", pkts_out, NUM_PKTS);
        report_counts();
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+verilog
verilog/ibuf_pkg.sv
verilog/ibuf_ram.sv
verilog/bkd2ibuf.sv
verilog/ibuf2hst.sv
verilog/rx_path_top.sv
verif/rx_path_props.sv
verif/rx_path_tb.sv

/* Bender.yml */
package:
  name: rx_path

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/ibuf_pkg.sv
      - verilog/ibuf_ram.sv
      - verilog/bkd2ibuf.sv
      - verilog/ibuf2hst.sv
      - verilog/rx_path_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verif/rx_path_props.sv
      - verif/rx_path_tb.sv
